// File: common/gfx_sp_config.svh
`ifndef GFX_SP_CONFIG_SVH
`define GFX_SP_CONFIG_SVH

// ----------------------------------------
// lane geometry
// ----------------------------------------

`define GFX_SP_LANES 4
`define GFX_SP_LANE_BITS 16

// vector register file size.
`define GFX_SP_VREGS 16

// instruction prefetch queue, power of two.
`define GFX_SP_FIFO_DEPTH 4

`define GFX_SP_ADDR_BITS 16

`endif

// File: common/gfx_sp_pkg.sv
`include "gfx_sp_config.svh"

package gfx_sp_pkg;

	typedef logic [31:0] vram_word;
	typedef logic [`GFX_SP_ADDR_BITS-1:0] vram_addr;
	typedef logic [15:0] cmd_word;
	typedef logic [31:0] insn_word;

	// ----------------------------------------
	// vector data
	// ----------------------------------------

	typedef logic [`GFX_SP_LANE_BITS-1:0] lane;
	typedef logic [`GFX_SP_LANES*`GFX_SP_LANE_BITS-1:0] lane_word;
	typedef logic [`GFX_SP_LANES-1:0] lane_mask;
	typedef logic [$clog2(`GFX_SP_VREGS)-1:0] vreg_num;

	// top nibble of an instruction word.
	typedef enum logic [3:0] {
		OP_NOP,
		OP_IMM,
		OP_ADD,
		OP_MUL,
		OP_RECV,
		OP_SEND
	} opcode_e;

	typedef enum logic [2:0] {
		FETCH_IDLE,
		FETCH_HDR_BASE,
		FETCH_HDR_LEN,
		FETCH_CODE,
		FETCH_DRAIN
	} fetch_state_e;

	typedef enum logic [1:0] {
		BATCH_IDLE,
		BATCH_READ,
		BATCH_HOLD
	} batch_state_e;

	typedef enum logic [1:0] {
		STREAM_IDLE,
		STREAM_RECV,
		STREAM_SEND,
		STREAM_WB
	} stream_state_e;

endpackage

// File: common/gfx_sp_if.sv
`timescale 1ns/1ps

// avalon style read-only master port.
interface gfx_sp_mem_if;
	import gfx_sp_pkg::*;

	vram_addr address;
	logic     read;
	logic     waitrequest;
	logic     readdatavalid;
	vram_word readdata;

	modport host
	(
		output address,
		       read,
		input  waitrequest,
		       readdatavalid,
		       readdata
	);
endinterface

// one result headed for the register file.
interface gfx_sp_wb_if;
	import gfx_sp_pkg::*;

	logic     valid;
	logic     ready;
	vreg_num  wreg;
	lane_word data;

	modport unit(output valid, wreg, data, input ready);
	modport writeback(input valid, wreg, data, output ready);
endinterface

// File: fetch/gfx_sp_fetch.sv
`timescale 1ns/1ps
`include "gfx_sp_config.svh"

module gfx_sp_fetch
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  program_start,
	input  gfx_sp_pkg::cmd_word   program_header_base,
	input  gfx_sp_pkg::cmd_word   program_header_size,
	gfx_sp_mem_if.host            mem,
	output logic                  batch_start,
	output gfx_sp_pkg::vram_addr  batch_base,
	output gfx_sp_pkg::cmd_word   batch_length,
	output gfx_sp_pkg::insn_word  insn,
	output logic                  valid,
	input  logic                  ready,
	input  logic                  decode_idle,
	input  logic                  batch_end,
	output logic                  running
);
	import gfx_sp_pkg::*;

	localparam int DEPTH = `GFX_SP_FIFO_DEPTH;
	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	fetch_state_e state;
	vram_addr addr, code_start, code_end;
	logic hdr_issued, accept, code_accept, push, pop;
	logic [CNT_BITS-1:0] count, pending;
	logic [CNT_BITS:0] in_use;
	logic [PTR_BITS-1:0] wr_ptr, rd_ptr;
	insn_word fifo[DEPTH];

	assign accept = mem.read && !mem.waitrequest;
	assign code_accept = accept && state == FETCH_CODE;
	assign push = mem.readdatavalid && (state == FETCH_CODE || state == FETCH_DRAIN);
	assign pop = valid && ready;
	assign valid = count != '0;
	assign insn = fifo[rd_ptr];
	assign mem.address = addr;

	// queued plus in flight, so a returning word always has a slot.
	assign in_use = count + pending;

	always_comb
		case (state)
			FETCH_HDR_BASE, FETCH_HDR_LEN: mem.read = !hdr_issued;
			FETCH_CODE: mem.read = addr != code_end && in_use < DEPTH;
			default: mem.read = 1'b0;
		endcase

	always_ff @(posedge clk)
		if (push)
			fifo[wr_ptr] <= mem.readdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FETCH_IDLE;
			running <= 1'b0;
			batch_start <= 1'b0;
			hdr_issued <= 1'b0;
			addr <= '0;
			count <= '0;
			pending <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			batch_start <= 1'b0;
			count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
			pending <= pending + CNT_BITS'(code_accept) - CNT_BITS'(push);

			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;

			// header and code words sit back to back.
			if (accept) begin
				addr <= addr + 1'b1;
				hdr_issued <= 1'b1;
			end

			case (state)
				FETCH_IDLE:
					if (program_start) begin
						addr <= vram_addr'(program_header_base);
						code_start <= vram_addr'(program_header_base + 16'd2);
						code_end <= vram_addr'(program_header_base + program_header_size);
						hdr_issued <= 1'b0;
						running <= 1'b1;
						state <= FETCH_HDR_BASE;
					end
				FETCH_HDR_BASE:
					if (mem.readdatavalid) begin
						batch_base <= vram_addr'(mem.readdata);
						hdr_issued <= 1'b0;
						state <= FETCH_HDR_LEN;
					end
				FETCH_HDR_LEN:
					if (mem.readdatavalid) begin
						batch_length <= cmd_word'(mem.readdata);
						batch_start <= 1'b1;
						state <= FETCH_CODE;
					end
				FETCH_CODE:
					if (addr == code_end)
						state <= FETCH_DRAIN;
				FETCH_DRAIN:
					if (pending == '0 && count == '0 && decode_idle) begin
						if (batch_end) begin
							running <= 1'b0;
							state <= FETCH_IDLE;
						end else begin
							addr <= code_start;
							state <= FETCH_CODE;
						end
					end
				default:
					state <= FETCH_IDLE;
			endcase
		end
	end

endmodule

// File: design/gfx_sp_decode.sv
`timescale 1ns/1ps
`include "gfx_sp_config.svh"

module gfx_sp_decode
(
	input  logic                  clk,
	input  logic                  rst,

	input  gfx_sp_pkg::insn_word  insn,
	input  logic                  valid,
	output logic                  ready,

	output gfx_sp_pkg::vreg_num   rd_a,
	output gfx_sp_pkg::vreg_num   rd_b,
	input  gfx_sp_pkg::lane_word  rd_a_data,
	input  gfx_sp_pkg::lane_word  rd_b_data,
	input  logic                  wb_done,
	input  gfx_sp_pkg::vreg_num   wb_done_reg,

	output logic                  stream_valid,
	output logic                  combiner_valid,
	input  logic                  stream_ready,
	input  logic                  combiner_ready,
	output gfx_sp_pkg::opcode_e   op,
	output gfx_sp_pkg::vreg_num   dst,
	output gfx_sp_pkg::lane_word  a,
	output gfx_sp_pkg::lane_word  b,
	output gfx_sp_pkg::lane       imm,
	output logic                  idle
);
	import gfx_sp_pkg::*;

	logic held, hazard, go, to_stream, to_combiner, uses_a, uses_b, uses_dst;
	logic [`GFX_SP_VREGS-1:0] busy;

	assign to_stream = op == OP_RECV || op == OP_SEND;
	assign to_combiner = op == OP_IMM || op == OP_ADD || op == OP_MUL;
	assign uses_a = op == OP_ADD || op == OP_MUL || op == OP_SEND;
	assign uses_b = op == OP_ADD || op == OP_MUL;
	assign uses_dst = to_stream || to_combiner;

	// raw and waw against every result still in flight.
	assign hazard = (uses_a && busy[rd_a]) || (uses_b && busy[rd_b]) || (uses_dst && busy[dst]);

	assign stream_valid = held && !hazard && to_stream;
	assign combiner_valid = held && !hazard && to_combiner;
	assign go = held && !hazard
	         && ((to_stream && stream_ready) || (to_combiner && combiner_ready) || !uses_dst);

	assign ready = !held || go;
	assign idle = !held && busy == '0;
	assign a = rd_a_data;
	assign b = rd_b_data;

	always_ff @(posedge clk)
		if (valid && ready) begin
			op <= opcode_e'(insn[31:28]);
			dst <= insn[27:24];
			rd_a <= insn[23:20];
			rd_b <= insn[19:16];
			imm <= insn[15:0];
		end

	always_ff @(posedge clk) begin
		if (rst) begin
			held <= 1'b0;
			busy <= '0;
		end else begin
			if (valid && ready)
				held <= 1'b1;
			else if (go)
				held <= 1'b0;

			if (wb_done)
				busy[wb_done_reg] <= 1'b0;
			if (go && uses_dst)
				busy[dst] <= 1'b1;
		end
	end

endmodule

// File: batch/gfx_sp_batch.sv
`timescale 1ns/1ps
`include "gfx_sp_config.svh"

module gfx_sp_batch
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  batch_start,
	input  gfx_sp_pkg::vram_addr  batch_base,
	input  gfx_sp_pkg::cmd_word   batch_length,
	gfx_sp_mem_if.host            mem,
	output gfx_sp_pkg::lane_word  out_data,
	output gfx_sp_pkg::lane_mask  out_mask,
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic                  batch_end
);
	import gfx_sp_pkg::*;

	localparam int LANES = `GFX_SP_LANES;
	localparam int WORD_BITS = $bits(vram_word);

	batch_state_e state;
	vram_addr addr;
	cmd_word remaining;
	logic [1:0] issued;
	logic upper;

	assign mem.address = addr;
	assign mem.read = state == BATCH_READ && issued != 2'd2;
	assign out_valid = state == BATCH_HOLD;

	// lanes past the end of the batch are masked off.
	always_comb
		for (int i = 0; i < LANES; i++)
			out_mask[i] = remaining > cmd_word'(i);

	// two lanes per word, low lane in the low half.
	always_ff @(posedge clk)
		if (mem.readdatavalid) begin
			if (upper)
				out_data[WORD_BITS +: WORD_BITS] <= mem.readdata;
			else
				out_data[0 +: WORD_BITS] <= mem.readdata;
		end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= BATCH_IDLE;
			batch_end <= 1'b0;
			addr <= '0;
			remaining <= '0;
			issued <= '0;
			upper <= 1'b0;
		end else begin
			if (mem.read && !mem.waitrequest) begin
				addr <= addr + 1'b1;
				issued <= issued + 1'b1;
			end

			if (mem.readdatavalid)
				upper <= !upper;

			case (state)
				BATCH_READ:
					if (mem.readdatavalid && upper)
						state <= BATCH_HOLD;
				BATCH_HOLD:
					if (out_ready) begin
						issued <= '0;
						if (remaining <= cmd_word'(LANES)) begin
							batch_end <= 1'b1;
							state <= BATCH_IDLE;
						end else begin
							remaining <= remaining - cmd_word'(LANES);
							state <= BATCH_READ;
						end
					end
				default: ;
			endcase

			if (batch_start) begin
				addr <= batch_base;
				remaining <= batch_length;
				issued <= '0;
				upper <= 1'b0;
				batch_end <= batch_length == '0;
				state <= batch_length == '0 ? BATCH_IDLE : BATCH_READ;
			end
		end
	end

endmodule

// File: design/gfx_sp_stream.sv
`timescale 1ns/1ps
`include "gfx_sp_config.svh"

module gfx_sp_stream
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  gfx_sp_pkg::opcode_e   op,
	input  gfx_sp_pkg::vreg_num   dst,
	input  gfx_sp_pkg::lane_word  a,
	input  gfx_sp_pkg::lane_word  recv_data,
	input  gfx_sp_pkg::lane_mask  recv_mask,
	input  logic                  recv_valid,
	output logic                  recv_ready,
	output logic                  send_valid,
	output gfx_sp_pkg::lane_word  send_data,
	output gfx_sp_pkg::lane_mask  send_mask,
	input  logic                  send_ready,
	gfx_sp_wb_if.unit             wb
);
	import gfx_sp_pkg::*;

	localparam int BITS = `GFX_SP_LANE_BITS;

	stream_state_e state;
	lane_mask cur_mask;
	lane_word kept;

	assign in_ready = state == STREAM_IDLE;
	assign recv_ready = state == STREAM_RECV;
	assign send_valid = state == STREAM_SEND;
	assign wb.valid = state == STREAM_WB;

	// the send value doubles as the write back value.
	assign send_data = wb.data;
	assign send_mask = cur_mask;

	always_comb
		for (int i = 0; i < `GFX_SP_LANES; i++)
			kept[i*BITS +: BITS] = recv_mask[i] ? recv_data[i*BITS +: BITS] : '0;

	always_ff @(posedge clk)
		if (in_valid && in_ready) begin
			wb.wreg <= dst;
			wb.data <= a;
		end else if (recv_valid && recv_ready) begin
			wb.data <= kept;
		end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= STREAM_IDLE;
			cur_mask <= '0;
		end else begin
			case (state)
				STREAM_IDLE:
					if (in_valid)
						state <= op == OP_RECV ? STREAM_RECV : STREAM_SEND;
				STREAM_RECV:
					if (recv_valid) begin
						cur_mask <= recv_mask;
						state <= STREAM_WB;
					end
				STREAM_SEND:
					if (send_ready)
						state <= STREAM_WB;
				default:
					if (wb.ready)
						state <= STREAM_IDLE;
			endcase
		end
	end

endmodule

// File: design/gfx_sp_combiner.sv
`timescale 1ns/1ps
`include "gfx_sp_config.svh"

module gfx_sp_combiner
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  gfx_sp_pkg::opcode_e   op,
	input  gfx_sp_pkg::vreg_num   dst,
	input  gfx_sp_pkg::lane_word  a,
	input  gfx_sp_pkg::lane_word  b,
	input  gfx_sp_pkg::lane       imm,
	gfx_sp_wb_if.unit             wb
);
	import gfx_sp_pkg::*;

	localparam int BITS = `GFX_SP_LANE_BITS;

	lane_word result;

	assign in_ready = !wb.valid || wb.ready;

	// lane-wise, wrapping at the lane width.
	always_comb
		for (int i = 0; i < `GFX_SP_LANES; i++)
			case (op)
				OP_ADD: result[i*BITS +: BITS] = a[i*BITS +: BITS] + b[i*BITS +: BITS];
				OP_MUL: result[i*BITS +: BITS] = a[i*BITS +: BITS] * b[i*BITS +: BITS];
				default: result[i*BITS +: BITS] = imm;
			endcase

	always_ff @(posedge clk)
		if (in_valid && in_ready) begin
			wb.data <= result;
			wb.wreg <= dst;
		end

	always_ff @(posedge clk)
		if (rst)
			wb.valid <= 1'b0;
		else if (in_valid && in_ready)
			wb.valid <= 1'b1;
		else if (wb.ready)
			wb.valid <= 1'b0;

endmodule

// File: design/gfx_sp_writeback.sv
`timescale 1ns/1ps
`include "gfx_sp_config.svh"

module gfx_sp_writeback
(
	input  logic                  clk,
	input  logic                  rst,
	gfx_sp_wb_if.writeback        stream_wb,
	gfx_sp_wb_if.writeback        combiner_wb,
	input  gfx_sp_pkg::vreg_num   rd_a,
	input  gfx_sp_pkg::vreg_num   rd_b,
	output gfx_sp_pkg::lane_word  rd_a_data,
	output gfx_sp_pkg::lane_word  rd_b_data,
	output logic                  wb_done,
	output gfx_sp_pkg::vreg_num   wb_done_reg
);
	import gfx_sp_pkg::*;

	lane_word regs[`GFX_SP_VREGS];
	lane_word wr_data;

	// ----------------------------------------
	// one write per cycle, combiner first
	// ----------------------------------------

	assign combiner_wb.ready = 1'b1;
	assign stream_wb.ready = !combiner_wb.valid;

	assign wb_done = combiner_wb.valid || stream_wb.valid;
	assign wb_done_reg = combiner_wb.valid ? combiner_wb.wreg : stream_wb.wreg;
	assign wr_data = combiner_wb.valid ? combiner_wb.data : stream_wb.data;

	assign rd_a_data = regs[rd_a];
	assign rd_b_data = regs[rd_b];

	always_ff @(posedge clk)
		if (rst) begin
			for (int i = 0; i < `GFX_SP_VREGS; i++)
				regs[i] <= '0;
		end else if (wb_done) begin
			regs[wb_done_reg] <= wr_data;
		end

endmodule

// File: design/gfx_sp.sv
`timescale 1ns/1ps

module gfx_sp
(
	input  logic                  clk,
	input  logic                  rst,

	input  logic                  program_start,
	input  gfx_sp_pkg::cmd_word   program_header_base,
	input  gfx_sp_pkg::cmd_word   program_header_size,

	input  logic                  batch_waitrequest,
	input  logic                  batch_readdatavalid,
	input  gfx_sp_pkg::vram_word  batch_readdata,
	output gfx_sp_pkg::vram_addr  batch_address,
	output logic                  batch_read,

	input  logic                  fetch_waitrequest,
	input  logic                  fetch_readdatavalid,
	input  gfx_sp_pkg::vram_word  fetch_readdata,
	output gfx_sp_pkg::vram_addr  fetch_address,
	output logic                  fetch_read,

	input  logic                  send_ready,
	output logic                  send_valid,
	output gfx_sp_pkg::lane_word  send_data,
	output gfx_sp_pkg::lane_mask  send_mask,
	output logic                  running
);
	import gfx_sp_pkg::*;

	logic batch_start, batch_end, insn_valid, insn_ready, decode_idle;
	logic stream_valid, stream_ready, combiner_valid, combiner_ready;
	logic recv_valid, recv_ready, wb_done;
	vram_addr batch_base;
	cmd_word batch_length;
	insn_word insn;
	vreg_num rd_a, rd_b, dst, wb_done_reg;
	lane_word rd_a_data, rd_b_data, a, b, recv_data;
	lane_mask recv_mask;
	lane imm;
	opcode_e op;

	gfx_sp_mem_if batch_mem();
	gfx_sp_mem_if fetch_mem();
	gfx_sp_wb_if stream_wb();
	gfx_sp_wb_if combiner_wb();

	// ----------------------------------------
	// memory ports
	// ----------------------------------------

	assign batch_address = batch_mem.address;
	assign batch_read = batch_mem.read;
	assign batch_mem.waitrequest = batch_waitrequest;
	assign batch_mem.readdatavalid = batch_readdatavalid;
	assign batch_mem.readdata = batch_readdata;

	assign fetch_address = fetch_mem.address;
	assign fetch_read = fetch_mem.read;
	assign fetch_mem.waitrequest = fetch_waitrequest;
	assign fetch_mem.readdatavalid = fetch_readdatavalid;
	assign fetch_mem.readdata = fetch_readdata;

	// ----------------------------------------
	// blocks
	// ----------------------------------------

	gfx_sp_fetch fetch(.mem(fetch_mem), .valid(insn_valid), .ready(insn_ready), .*);

	gfx_sp_decode decode(.valid(insn_valid), .ready(insn_ready), .idle(decode_idle), .*);

	gfx_sp_batch batch
	(
		.mem(batch_mem),
		.out_data(recv_data),
		.out_mask(recv_mask),
		.out_valid(recv_valid),
		.out_ready(recv_ready),
		.*
	);

	gfx_sp_stream stream(.in_valid(stream_valid), .in_ready(stream_ready), .wb(stream_wb), .*);

	gfx_sp_combiner combiner
	(
		.in_valid(combiner_valid),
		.in_ready(combiner_ready),
		.wb(combiner_wb),
		.*
	);

	gfx_sp_writeback writeback(.stream_wb(stream_wb), .combiner_wb(combiner_wb), .*);

endmodule

// File: testbench/gfx_sp_mem_model.sv
`timescale 1ns/1ps

module gfx_sp_mem_model
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  stall,
	input  gfx_sp_pkg::vram_addr  address,
	input  logic                  read,
	input  gfx_sp_pkg::vram_word  mem_word,
	output logic                  waitrequest,
	output logic                  readdatavalid,
	output gfx_sp_pkg::vram_word  readdata
);
	import gfx_sp_pkg::*;

	logic stage_valid = 1'b0;
	logic out_valid = 1'b0;
	vram_word stage_data = '0;
	vram_word out_data = '0;

	assign waitrequest = stall;
	assign readdatavalid = out_valid;
	assign readdata = out_data;

	// two stages from accept to data.
	always @(posedge clk) begin
		if (rst) begin
			stage_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			stage_valid <= read && !waitrequest;
			out_valid <= stage_valid;
		end
		stage_data <= mem_word;
		out_data <= stage_data;
	end

endmodule

// File: testbench/gfx_sp_tb.sv
`timescale 1ns/1ps

module gfx_sp_tb;
	import gfx_sp_pkg::*;

	// lane groups over every test below.
	localparam int GROUPS = 17;
	localparam int CYCLE_LIMIT = 400 * GROUPS + 20;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic program_start = 1'b0;
	cmd_word program_header_base = '0;
	cmd_word program_header_size = '0;
	logic send_ready = 1'b1;
	logic batch_stall = 1'b0;
	logic fetch_stall = 1'b0;
	logic batch_waitrequest, batch_readdatavalid, batch_read;
	logic fetch_waitrequest, fetch_readdatavalid, fetch_read;
	vram_word batch_readdata, fetch_readdata, batch_word, fetch_word;
	vram_addr batch_address, fetch_address;
	logic send_valid, running;
	lane_word send_data;
	lane_mask send_mask;

	vram_word vram[65536];
	insn_word prog[8];
	int prog_len, sends_per_prog, exp_sends, sent, test_errors;
	int tests_run = 0;
	int tests_passed = 0;
	vram_addr batch_base;
	cmd_word batch_len;
	string test_name = "reset";
	logic jitter = 1'b0;
	logic [31:0] flow_seed = 32'd53;
	logic [31:0] data_seed = 32'd53;

	gfx_sp uut(.*);

	gfx_sp_mem_model batch_model(.stall(batch_stall), .address(batch_address), .read(batch_read),
		.mem_word(batch_word), .waitrequest(batch_waitrequest),
		.readdatavalid(batch_readdatavalid), .readdata(batch_readdata), .clk(clk), .rst(rst));

	gfx_sp_mem_model fetch_model(.stall(fetch_stall), .address(fetch_address), .read(fetch_read),
		.mem_word(fetch_word), .waitrequest(fetch_waitrequest),
		.readdatavalid(fetch_readdatavalid), .readdata(fetch_readdata), .clk(clk), .rst(rst));

	assign batch_word = vram[batch_address];
	assign fetch_word = vram[fetch_address];

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic insn_word encode(input opcode_e op, input vreg_num d, input vreg_num sa,
			input vreg_num sb, input lane imm);
		return {op, d, sa, sb, imm};
	endfunction

	// ----------------------------------------
	// reference model
	// ----------------------------------------

	function automatic lane batch_lane(input int grp, input int l);
		int idx;
		vram_word w;
		idx = grp * 4 + l;
		if (idx >= batch_len)
			return '0;
		w = vram[batch_base + idx / 2];
		return (idx % 2) ? w[31:16] : w[15:0];
	endfunction

	function automatic lane_mask ref_mask(input int grp);
		lane_mask m;
		for (int l = 0; l < 4; l++)
			m[l] = grp * 4 + l < batch_len;
		return m;
	endfunction

	// one lane at a time, programs write every register before reading it.
	function automatic lane_word ref_send(input int grp, input int nth);
		lane_word result;
		lane regs[16];
		opcode_e op;
		vreg_num d, sa, sb;
		int seen;
		result = '0;
		for (int l = 0; l < 4; l++) begin
			for (int r = 0; r < 16; r++)
				regs[r] = '0;
			seen = 0;
			for (int pc = 0; pc < prog_len; pc++) begin
				op = opcode_e'(prog[pc][31:28]);
				d = prog[pc][27:24];
				sa = prog[pc][23:20];
				sb = prog[pc][19:16];
				case (op)
					OP_IMM: regs[d] = prog[pc][15:0];
					OP_ADD: regs[d] = regs[sa] + regs[sb];
					OP_MUL: regs[d] = regs[sa] * regs[sb];
					OP_RECV: regs[d] = batch_lane(grp, l);
					OP_SEND: begin
						if (seen == nth)
							result[l*16 +: 16] = regs[sa];
						seen++;
						regs[d] = regs[sa];
					end
					default: ;
				endcase
			end
		end
		return result;
	endfunction

	task automatic check_lanes(input string name, input lane_word expected, input lane_word actual);
		if (actual !== expected) begin
			$display("mismatch %s lanes: expected %h, actual %h", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_mask(input string name, input lane_mask expected, input lane_mask actual);
		if (actual !== expected) begin
			$display("mismatch %s mask: expected %b, actual %b", name, expected, actual);
			test_errors++;
		end
	endtask

	// ----------------------------------------
	// stimulus and comparison
	// ----------------------------------------

	always @(posedge clk) begin
		#1;
		if (jitter) begin
			flow_seed = lcg_step(flow_seed);
			batch_stall = flow_seed[31:30] == 2'b00;
			flow_seed = lcg_step(flow_seed);
			fetch_stall = flow_seed[31:30] == 2'b00;
			flow_seed = lcg_step(flow_seed);
			send_ready = flow_seed[31:30] != 2'b00;
		end else begin
			batch_stall = 1'b0;
			fetch_stall = 1'b0;
			send_ready = 1'b1;
		end
	end

	always @(posedge clk)
		if (!rst && send_valid && send_ready) begin
			if (sent >= exp_sends) begin
				$display("%s: unexpected send beyond the expected %0d", test_name, exp_sends);
				test_errors++;
			end else begin
				check_lanes(test_name, ref_send(sent / sends_per_prog, sent % sends_per_prog),
					send_data);
				check_mask(test_name, ref_mask(sent / sends_per_prog), send_mask);
			end
			sent++;
		end

	task automatic run_program(input string name, input vram_addr hdr, input vram_addr base,
			input cmd_word len, input logic rnd);
		int words;
		words = (len + 3) / 4 * 2;
		vram[hdr] = base;
		vram[hdr + 1] = len;
		for (int i = 0; i < prog_len; i++)
			vram[hdr + 2 + i] = prog[i];
		for (int i = 0; i < words; i++) begin
			data_seed = lcg_step(data_seed);
			vram[base + i] = data_seed;
		end
		sends_per_prog = 0;
		for (int i = 0; i < prog_len; i++)
			if (prog[i][31:28] == OP_SEND)
				sends_per_prog++;
		test_name = name;
		batch_base = base;
		batch_len = len;
		exp_sends = (len + 3) / 4 * sends_per_prog;
		sent = 0;
		test_errors = 0;
		jitter = rnd;
		@(posedge clk);
		#1;
		program_header_base = hdr;
		program_header_size = cmd_word'(prog_len + 2);
		program_start = 1'b1;
		@(posedge clk);
		#1;
		program_start = 1'b0;
		if (!running) begin
			$display("%s: running did not rise after program_start", name);
			test_errors++;
		end
		while (running) begin
			@(posedge clk);
			#1;
		end
		repeat (2) @(posedge clk);
		#1;
		if (sent < exp_sends) begin
			$display("%s: only %0d of %0d sends arrived", name, sent, exp_sends);
			test_errors++;
		end
		tests_run++;
		if (test_errors == 0) begin
			tests_passed++;
			$display("%s: pass, %0d sends", name, sent);
		end else begin
			$display("%s: fail, %0d errors", name, test_errors);
		end
	endtask

	initial begin
		for (int i = 0; i < 65536; i++)
			vram[i] = {16'hffff ^ i[15:0], i[15:0]};
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		prog[0] = encode(OP_RECV, 1, 0, 0, 0);
		prog[1] = encode(OP_SEND, 1, 1, 0, 0);
		prog_len = 2;
		run_program("pass_through", 16'h0000, 16'h0100, 6, 1'b0);

		prog[0] = encode(OP_IMM, 1, 0, 0, 16'h0123);
		prog[1] = encode(OP_RECV, 2, 0, 0, 0);
		prog[2] = encode(OP_ADD, 3, 2, 1, 0);
		prog[3] = encode(OP_MUL, 4, 3, 2, 0);
		prog[4] = encode(OP_SEND, 5, 4, 0, 0);
		prog_len = 5;
		run_program("arithmetic", 16'h0010, 16'h0200, 9, 1'b0);

		// each add waits on the one before.
		prog[0] = encode(OP_RECV, 1, 0, 0, 0);
		prog[1] = encode(OP_ADD, 2, 1, 1, 0);
		prog[2] = encode(OP_ADD, 3, 2, 1, 0);
		prog[3] = encode(OP_ADD, 2, 3, 2, 0);
		prog[4] = encode(OP_SEND, 2, 2, 0, 0);
		prog_len = 5;
		run_program("hazards", 16'h0020, 16'h0300, 8, 1'b0);

		prog[0] = encode(OP_RECV, 1, 0, 0, 0);
		prog[1] = encode(OP_IMM, 2, 0, 0, 16'd7);
		prog[2] = encode(OP_MUL, 3, 1, 2, 0);
		prog[3] = encode(OP_SEND, 3, 3, 0, 0);
		prog[4] = encode(OP_ADD, 4, 3, 1, 0);
		prog[5] = encode(OP_SEND, 4, 4, 0, 0);
		prog_len = 6;
		run_program("back_pressure", 16'h0030, 16'h0400, 16, 1'b1);

		prog[0] = encode(OP_RECV, 6, 0, 0, 0);
		prog[1] = encode(OP_ADD, 7, 6, 6, 0);
		prog[2] = encode(OP_SEND, 8, 7, 0, 0);
		prog[3] = encode(OP_SEND, 6, 6, 0, 0);
		prog_len = 4;
		run_program("loop_long", 16'h0040, 16'h0500, 20, 1'b1);
		run_program("restart", 16'h0050, 16'h0600, 3, 1'b1);

		$display("%0d tests run, %0d passed, %0d failed", tests_run, tests_passed,
			tests_run - tests_passed);
		if (tests_passed == tests_run)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		repeat (CYCLE_LIMIT) @(posedge clk);
		$display("timeout: %s did not finish within %0d cycles", test_name, CYCLE_LIMIT);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: gfx_sp.f
+incdir+common
common/gfx_sp_pkg.sv
common/gfx_sp_if.sv
fetch/gfx_sp_fetch.sv
design/gfx_sp_decode.sv
batch/gfx_sp_batch.sv
design/gfx_sp_stream.sv
design/gfx_sp_combiner.sv
design/gfx_sp_writeback.sv
design/gfx_sp.sv
testbench/gfx_sp_mem_model.sv
testbench/gfx_sp_tb.sv
